/* Makefile */
VERILATOR  := verilator
TOP        := tb_ooo_core
FILELIST   := files.f
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP)
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
src/ooo_pkg.sv
src/rename_table.sv
src/reorder_buffer.sv
src/reservation_alu.sv
src/ooo_core_top.sv
tb/tb_ooo_core.sv

/* src/ooo_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ooo_core_top import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8,
  parameter int RS_DEPTH  = 4
) (
  input  logic    in_clk,
  input  logic    in_rst_n,
  input  logic    dispatch_valid,
  input  insn_t   insn,
  output logic    dispatch_ready,
  output commit_t commit
);

  logic             accept;
  logic [TAG_W-1:0] alloc_tag;
  logic             rob_free;
  logic             rs_free;
  rename_req_t      rename_req;
  rs_entry_t        rs_packet;
  fu_result_t       fu_result;
  broadcast_t       broadcast;

  // Strobes while not ready are dropped
  assign dispatch_ready = rob_free && rs_free;
  assign accept         = dispatch_valid && dispatch_ready;

  rename_table rename_table_inst (
    .in_clk     (in_clk),
    .in_rst_n   (in_rst_n),
    .accept     (accept),
    .insn       (insn),
    .alloc_tag  (alloc_tag),
    .rename_req (rename_req),
    .commit     (commit)
  );

  reorder_buffer #(
    .ROB_DEPTH (ROB_DEPTH)
  ) reorder_buffer_inst (
    .in_clk     (in_clk),
    .in_rst_n   (in_rst_n),
    .accept     (accept),
    .rename_req (rename_req),
    .alloc_tag  (alloc_tag),
    .rob_free   (rob_free),
    .rs_packet  (rs_packet),
    .fu_result  (fu_result),
    .broadcast  (broadcast),
    .commit     (commit)
  );

  reservation_alu #(
    .RS_DEPTH (RS_DEPTH)
  ) reservation_alu_inst (
    .in_clk    (in_clk),
    .in_rst_n  (in_rst_n),
    .rs_packet (rs_packet),
    .broadcast (broadcast),
    .rs_free   (rs_free),
    .fu_result (fu_result)
  );

endmodule

`default_nettype wire

/* src/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

  localparam int XLEN      = 32;
  localparam int NUM_GPR   = 16;
  localparam int GPR_IDX_W = 4;
  localparam int TAG_W     = 5;   // Enough for 32 reorder entries
  localparam int IMM_W     = 12;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_ADDI = 3'd3,
    OP_MUL  = 3'd4,  // Three-cycle pipe
    OP_CSEL = 3'd5
  } op_e;

  typedef enum logic [1:0] {
    COND_EQ = 2'd0,
    COND_NE = 2'd1,
    COND_LT = 2'd2,
    COND_GE = 2'd3
  } cond_e;

  // Second operand word, decoded by opcode
  typedef struct packed {
    logic [GPR_IDX_W-1:0] src2;
    cond_e                cond;
    logic [9:0]           pad;
  } operand2_reg_t;

  typedef struct packed {
    logic [IMM_W-1:0] imm;
    logic [3:0]       pad;
  } operand2_imm_t;

  typedef union packed {
    operand2_reg_t reg_op;
    operand2_imm_t imm_op;  // ADDI only
  } operand2_u;

  typedef struct packed {
    op_e                  op;
    logic [GPR_IDX_W-1:0] dst;
    logic [GPR_IDX_W-1:0] src1;
    operand2_u            operand2;
    logic                 set_flags;
  } insn_t;

  // Source lookup result, a value when ready and a tag otherwise
  typedef struct packed {
    logic                 src1_ready;
    logic [XLEN-1:0]      src1_value;
    logic [TAG_W-1:0]     src1_tag;
    logic                 src2_ready;
    logic [XLEN-1:0]      src2_value;
    logic [TAG_W-1:0]     src2_tag;
    logic                 flags_ready;
    nzcv_t                flags;
    logic [TAG_W-1:0]     flags_tag;
    logic [GPR_IDX_W-1:0] dst;
    op_e                  op;
    logic [IMM_W-1:0]     imm;
    cond_e                cond;
    logic                 set_flags;
    logic                 use_src2;
    logic                 use_flags;
  } rename_req_t;

  typedef struct packed {
    logic             valid;
    logic             src1_ready;
    logic [XLEN-1:0]  src1_value;
    logic [TAG_W-1:0] src1_tag;
    logic             src2_ready;
    logic [XLEN-1:0]  src2_value;
    logic [TAG_W-1:0] src2_tag;
    logic             flags_ready;
    nzcv_t            flags;
    logic [TAG_W-1:0] flags_tag;
    logic [TAG_W-1:0] dst_tag;
    op_e              op;
    logic [IMM_W-1:0] imm;
    cond_e            cond;
    logic             set_flags;
  } rs_entry_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  value;
    logic             set_flags;
    nzcv_t            nzcv;
  } fu_result_t;

  typedef fu_result_t broadcast_t;  // Same layout, driven from the stored entry

  typedef struct packed {
    logic                 valid;
    logic [TAG_W-1:0]     tag;
    logic [GPR_IDX_W-1:0] dst;
    logic [XLEN-1:0]      value;
    logic                 set_flags;
    nzcv_t                nzcv;
  } commit_t;

endpackage

`default_nettype wire

/* src/rename_table.sv */
`timescale 1ns/10ps
`default_nettype none

module rename_table import ooo_pkg::*; (
  input  logic             in_clk,
  input  logic             in_rst_n,
  input  logic             accept,
  input  insn_t            insn,
  input  logic [TAG_W-1:0] alloc_tag,
  output rename_req_t      rename_req,
  input  commit_t          commit
);

  // Architectural state
  logic [XLEN-1:0]    gpr_value [NUM_GPR];
  logic [NUM_GPR-1:0] gpr_pending;
  logic [TAG_W-1:0]   gpr_tag [NUM_GPR];
  nzcv_t              flags;
  logic               flags_pending;
  logic [TAG_W-1:0]   flags_tag;

  logic [GPR_IDX_W-1:0] src2_idx;
  logic                 flag_write;
  logic                 uses_src2;
  logic                 uses_flags;

  assign src2_idx   = insn.operand2.reg_op.src2;
  assign uses_src2  = (insn.op != OP_ADDI);
  assign uses_flags = (insn.op == OP_CSEL);
  // MUL and CSEL never write flags
  assign flag_write = insn.set_flags &&
                      (insn.op inside {OP_ADD, OP_SUB, OP_ADDI, OP_AND});

  always_comb begin
    rename_req = '0;
    rename_req.src1_ready  = !gpr_pending[insn.src1];
    rename_req.src1_value  = gpr_value[insn.src1];
    rename_req.src1_tag    = gpr_tag[insn.src1];
    rename_req.src2_ready  = !gpr_pending[src2_idx];
    rename_req.src2_value  = gpr_value[src2_idx];
    rename_req.src2_tag    = gpr_tag[src2_idx];
    rename_req.flags_ready = !flags_pending;
    rename_req.flags       = flags;
    rename_req.flags_tag   = flags_tag;
    rename_req.dst         = insn.dst;
    rename_req.op          = insn.op;
    rename_req.imm         = insn.operand2.imm_op.imm;
    rename_req.cond        = insn.operand2.reg_op.cond;
    rename_req.set_flags   = flag_write;
    rename_req.use_src2    = uses_src2;
    rename_req.use_flags   = uses_flags;
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      for (int i = 0; i < NUM_GPR; i++) begin
        gpr_value[i] <= '0;
        gpr_tag[i]   <= '0;
      end
      gpr_pending   <= '0;
      flags         <= '0;
      flags_pending <= 1'b0;
      flags_tag     <= '0;
    end else begin
      if (commit.valid) begin
        gpr_value[commit.dst] <= commit.value;
        // Only the youngest writer releases the register
        if (gpr_pending[commit.dst] && gpr_tag[commit.dst] == commit.tag) begin
          gpr_pending[commit.dst] <= 1'b0;
        end
        if (commit.set_flags) begin
          flags <= commit.nzcv;
          if (flags_pending && flags_tag == commit.tag) begin
            flags_pending <= 1'b0;
          end
        end
      end
      // Later assignment, so a same-edge rename beats the commit release
      if (accept) begin
        gpr_pending[insn.dst] <= 1'b1;
        gpr_tag[insn.dst]     <= alloc_tag;
        if (flag_write) begin
          flags_pending <= 1'b1;
          flags_tag     <= alloc_tag;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/reorder_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  logic             in_clk,
  input  logic             in_rst_n,
  input  logic             accept,
  input  rename_req_t      rename_req,
  output logic [TAG_W-1:0] alloc_tag,
  output logic             rob_free,
  output rs_entry_t        rs_packet,
  input  fu_result_t       fu_result,
  output broadcast_t       broadcast,
  output commit_t          commit
);

  localparam int IDX_W = $clog2(ROB_DEPTH);
  localparam int CNT_W = IDX_W + 1;

  // Entry array
  logic [ROB_DEPTH-1:0] ent_done;
  logic [GPR_IDX_W-1:0] ent_dst [ROB_DEPTH];
  logic [XLEN-1:0]      ent_value [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] ent_set_flags;
  nzcv_t                ent_nzcv [ROB_DEPTH];

  logic [IDX_W-1:0] head;  // Oldest in flight
  logic [IDX_W-1:0] tail;  // Next to allocate
  logic [CNT_W-1:0] count;

  logic             bc_valid;
  logic [IDX_W-1:0] bc_idx;

  logic [IDX_W-1:0] fu_idx;
  logic [IDX_W-1:0] s1_idx;
  logic [IDX_W-1:0] s2_idx;
  logic [IDX_W-1:0] sf_idx;
  logic             do_commit;
  rs_entry_t        pkt_next;

  assign fu_idx    = fu_result.tag[IDX_W-1:0];
  assign s1_idx    = rename_req.src1_tag[IDX_W-1:0];
  assign s2_idx    = rename_req.src2_tag[IDX_W-1:0];
  assign sf_idx    = rename_req.flags_tag[IDX_W-1:0];
  assign do_commit = ent_done[head];
  assign alloc_tag = TAG_W'(tail);
  assign rob_free  = (count != CNT_W'(ROB_DEPTH));

  // Resolve pending sources from entries that already hold results
  always_comb begin
    pkt_next = '0;
    pkt_next.valid = accept;

    pkt_next.src1_ready = rename_req.src1_ready || ent_done[s1_idx];
    pkt_next.src1_value = rename_req.src1_ready ? rename_req.src1_value : ent_value[s1_idx];
    pkt_next.src1_tag   = rename_req.src1_tag;

    pkt_next.src2_ready = !rename_req.use_src2 || rename_req.src2_ready || ent_done[s2_idx];
    pkt_next.src2_value = rename_req.src2_ready ? rename_req.src2_value : ent_value[s2_idx];
    pkt_next.src2_tag   = rename_req.src2_tag;

    pkt_next.flags_ready = !rename_req.use_flags || rename_req.flags_ready ||
                           ent_done[sf_idx];
    pkt_next.flags       = rename_req.flags_ready ? rename_req.flags : ent_nzcv[sf_idx];
    pkt_next.flags_tag   = rename_req.flags_tag;

    pkt_next.dst_tag   = TAG_W'(tail);
    pkt_next.op        = rename_req.op;
    pkt_next.imm       = rename_req.imm;
    pkt_next.cond      = rename_req.cond;
    pkt_next.set_flags = rename_req.set_flags;
  end

  // Pointers, done bits, broadcast slot and the station packet
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      ent_done  <= '0;
      bc_valid  <= 1'b0;
      bc_idx    <= '0;
      rs_packet <= '0;
    end else begin
      rs_packet <= pkt_next;  // Valid for the one cycle after acceptance
      bc_valid  <= fu_result.valid;
      bc_idx    <= fu_idx;
      if (do_commit) begin
        ent_done[head] <= 1'b0;
        head           <= head + 1'b1;
      end
      if (fu_result.valid) begin
        ent_done[fu_idx] <= 1'b1;
      end
      if (accept) begin
        ent_done[tail] <= 1'b0;
        tail           <= tail + 1'b1;
      end
      count <= count + CNT_W'(accept) - CNT_W'(do_commit);
    end
  end

  always_ff @(posedge in_clk) begin
    if (accept) begin
      ent_dst[tail]       <= rename_req.dst;
      ent_set_flags[tail] <= rename_req.set_flags;
    end
    if (fu_result.valid) begin
      ent_value[fu_idx] <= fu_result.value;
      if (fu_result.set_flags) begin
        ent_nzcv[fu_idx] <= fu_result.nzcv;
      end
    end
  end

  // Result goes out one cycle after it lands in the entry
  always_comb begin
    broadcast.valid     = bc_valid;
    broadcast.tag       = TAG_W'(bc_idx);
    broadcast.value     = ent_value[bc_idx];
    broadcast.set_flags = ent_set_flags[bc_idx];
    broadcast.nzcv      = ent_nzcv[bc_idx];
  end

  always_comb begin
    commit.valid     = do_commit;
    commit.tag       = TAG_W'(head);
    commit.dst       = ent_dst[head];
    commit.value     = ent_value[head];
    commit.set_flags = ent_set_flags[head];
    commit.nzcv      = ent_nzcv[head];
  end

endmodule

`default_nettype wire

/* src/reservation_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module reservation_alu import ooo_pkg::*; #(
  parameter int RS_DEPTH = 4
) (
  input  logic       in_clk,
  input  logic       in_rst_n,
  input  rs_entry_t  rs_packet,
  input  broadcast_t broadcast,
  output logic       rs_free,
  output fu_result_t fu_result
);

  localparam int RS_IDX_W = $clog2(RS_DEPTH);

  // Slot 0 is always the oldest, younger entries collapse down on issue
  rs_entry_t           slot [RS_DEPTH];
  rs_entry_t           slot_nxt [RS_DEPTH];
  logic [RS_DEPTH-1:0] slot_valid;
  logic [RS_DEPTH-1:0] valid_nxt;
  logic [RS_DEPTH-1:0] can_issue;

  logic                issue_fire;
  logic [RS_IDX_W-1:0] issue_idx;
  logic                issue_mul;
  rs_entry_t           iss;

  // MUL pipe
  logic             m1_valid;
  logic [TAG_W-1:0] m1_tag;
  logic [XLEN-1:0]  m1_a;
  logic [XLEN-1:0]  m1_b;
  logic             m2_valid;
  logic [TAG_W-1:0] m2_tag;
  logic [XLEN-1:0]  m2_prod;

  function automatic rs_entry_t snoop(rs_entry_t e, broadcast_t bc);
    rs_entry_t r;
    r = e;
    if (bc.valid) begin
      if (!e.src1_ready && e.src1_tag == bc.tag) begin
        r.src1_ready = 1'b1;
        r.src1_value = bc.value;
      end
      if (!e.src2_ready && e.src2_tag == bc.tag) begin
        r.src2_ready = 1'b1;
        r.src2_value = bc.value;
      end
      if (!e.flags_ready && bc.set_flags && e.flags_tag == bc.tag) begin
        r.flags_ready = 1'b1;
        r.flags       = bc.nzcv;
      end
    end
    return r;
  endfunction

  function automatic fu_result_t alu_exec(rs_entry_t e);
    fu_result_t      r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] bx;
    logic [XLEN:0]   sum;
    logic            sub;
    logic            hold;
    a   = e.src1_value;
    b   = (e.op == OP_ADDI) ? XLEN'(e.imm) : e.src2_value;
    sub = (e.op == OP_SUB);
    bx  = sub ? ~b : b;
    sum = {1'b0, a} + {1'b0, bx} + {{XLEN{1'b0}}, sub};  // Subtract as a + ~b + 1
    case (e.cond)
      COND_EQ: hold = e.flags.z;
      COND_NE: hold = !e.flags.z;
      COND_LT: hold = (e.flags.n != e.flags.v);
      default: hold = (e.flags.n == e.flags.v);
    endcase
    r           = '0;
    r.valid     = 1'b1;
    r.tag       = e.dst_tag;
    r.set_flags = e.set_flags;
    case (e.op)
      OP_AND:  r.value = a & b;  // c and v stay 0
      OP_CSEL: r.value = hold ? a : b;
      default: begin
        r.value  = sum[XLEN-1:0];
        r.nzcv.c = sum[XLEN];  // Carry, or not-borrow on SUB
        r.nzcv.v = (a[XLEN-1] == bx[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
      end
    endcase
    r.nzcv.n = r.value[XLEN-1];
    r.nzcv.z = (r.value == '0);
    return r;
  endfunction

  // A simple op may not finish on the same edge as the MUL in stage 2
  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      can_issue[i] = slot_valid[i] && slot[i].src1_ready && slot[i].src2_ready &&
                     slot[i].flags_ready && (slot[i].op == OP_MUL || !m2_valid);
    end
    issue_fire = 1'b0;
    issue_idx  = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (can_issue[i]) begin
        issue_fire = 1'b1;
        issue_idx  = RS_IDX_W'(i);
      end
    end
  end

  assign iss       = slot[issue_idx];
  assign issue_mul = (iss.op == OP_MUL);
  assign rs_free   = ($countones(~slot_valid) >= 2);  // One more may already be on the way

  always_comb begin
    int n;
    n = 0;
    valid_nxt = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      slot_nxt[i] = '0;
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (slot_valid[i] && !(issue_fire && issue_idx == RS_IDX_W'(i))) begin
        slot_nxt[n]  = snoop(slot[i], broadcast);
        valid_nxt[n] = 1'b1;
        n++;
      end
    end
    // New packet also sees this cycle's broadcast
    if (rs_packet.valid && n < RS_DEPTH) begin
      slot_nxt[n]  = snoop(rs_packet, broadcast);
      valid_nxt[n] = 1'b1;
    end
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      slot_valid <= '0;
      m1_valid   <= 1'b0;
      m2_valid   <= 1'b0;
      fu_result  <= '0;
    end else begin
      slot_valid <= valid_nxt;
      m1_valid   <= issue_fire && issue_mul;
      m2_valid   <= m1_valid;
      if (m2_valid) begin
        fu_result <= fu_result_t'{valid: 1'b1, tag: m2_tag, value: m2_prod,
                                  set_flags: 1'b0, nzcv: '0};
      end else if (issue_fire && !issue_mul) begin
        fu_result <= alu_exec(iss);
      end else begin
        fu_result.valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    slot    <= slot_nxt;
    m1_tag  <= iss.dst_tag;
    m1_a    <= iss.src1_value;
    m1_b    <= iss.src2_value;
    m2_tag  <= m1_tag;
    m2_prod <= m1_a * m1_b;  // Low word only
  end

endmodule

`default_nettype wire

/* tb/tb_ooo_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ooo_core import ooo_pkg::*; ();

  localparam int ROB_DEPTH   = 8;
  localparam int RS_DEPTH    = 4;
  localparam int WAIT_LIMIT  = 200;   // Cycles
  localparam int DRAIN_LIMIT = 5000;

  logic    in_clk;
  logic    in_rst_n;
  logic    dispatch_valid;
  insn_t   insn;
  logic    dispatch_ready;
  commit_t commit;

  // Reference state in program order
  logic [XLEN-1:0]  model_gpr [NUM_GPR];
  nzcv_t            model_flags;
  logic [TAG_W-1:0] next_tag;
  commit_t          exp_q [$];
  int               dropped;
  logic [31:0]      lfsr;

  ooo_core_top #(
    .ROB_DEPTH (ROB_DEPTH),
    .RS_DEPTH  (RS_DEPTH)
  ) ooo_core_top_inst (
    .in_clk         (in_clk),
    .in_rst_n       (in_rst_n),
    .dispatch_valid (dispatch_valid),
    .insn           (insn),
    .dispatch_ready (dispatch_ready),
    .commit         (commit)
  );

  initial in_clk = 1'b0;
  always #2 in_clk = ~in_clk;

  task automatic report_failure(string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      r[i] = lfsr[0];
    end
    return r;
  endfunction

  function automatic insn_t make_insn(op_e op, int dst, int src1, int src2, cond_e cond,
                                      int imm, logic set_flags);
    insn_t in;
    in = '0;
    in.op        = op;
    in.dst       = GPR_IDX_W'(dst);
    in.src1      = GPR_IDX_W'(src1);
    in.set_flags = set_flags;
    if (op == OP_ADDI) begin
      in.operand2.imm_op.imm = IMM_W'(imm);
    end else begin
      in.operand2.reg_op.src2 = GPR_IDX_W'(src2);
      in.operand2.reg_op.cond = cond;
    end
    return in;
  endfunction

  // Applies one accepted instruction and queues its expected commit
  function automatic void model_apply(insn_t in);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    logic [XLEN:0]   wide;
    logic            hold;
    logic            writes_flags;
    nzcv_t           f;
    commit_t         exp;
    a = model_gpr[in.src1];
    b = (in.op == OP_ADDI) ? XLEN'(in.operand2.imm_op.imm) : model_gpr[in.operand2.reg_op.src2];
    f = '0;
    case (in.operand2.reg_op.cond)
      COND_EQ: hold = model_flags.z;
      COND_NE: hold = !model_flags.z;
      COND_LT: hold = (model_flags.n != model_flags.v);
      default: hold = (model_flags.n == model_flags.v);
    endcase
    case (in.op)
      OP_SUB: begin
        r   = a - b;
        f.c = (a >= b);  // No borrow
        f.v = (a[XLEN-1] != b[XLEN-1]) && (r[XLEN-1] != a[XLEN-1]);
      end
      OP_AND:  r = a & b;
      OP_MUL:  r = a * b;
      OP_CSEL: r = hold ? a : b;
      default: begin
        wide = {1'b0, a} + {1'b0, b};
        r    = wide[XLEN-1:0];
        f.c  = wide[XLEN];
        f.v  = (a[XLEN-1] == b[XLEN-1]) && (r[XLEN-1] != a[XLEN-1]);
      end
    endcase
    f.n = r[XLEN-1];
    f.z = (r == '0);
    writes_flags = in.set_flags && (in.op inside {OP_ADD, OP_SUB, OP_ADDI, OP_AND});
    exp = '{valid: 1'b1, tag: next_tag, dst: in.dst, value: r,
            set_flags: writes_flags, nzcv: writes_flags ? f : 4'b0000};
    if (writes_flags) begin
      model_flags = f;
    end
    model_gpr[in.dst] = r;
    next_tag = TAG_W'((int'(next_tag) + 1) % ROB_DEPTH);
    exp_q.push_back(exp);
  endfunction

  task automatic idle(int n);
    repeat (n) begin
      @(posedge in_clk);
      #1;
    end
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (!dispatch_ready) begin
      @(posedge in_clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) report_failure("Timeout waiting for dispatch_ready");
    end
  endtask

  task automatic send(insn_t in);
    wait_ready();
    insn           = in;
    dispatch_valid = 1'b1;
    model_apply(in);
    @(posedge in_clk);
    #1;
    dispatch_valid = 1'b0;
  endtask

  // Strobes whether or not ready is high
  task automatic strobe_blind(insn_t in);
    insn           = in;
    dispatch_valid = 1'b1;
    if (dispatch_ready) begin
      model_apply(in);
    end else begin
      dropped++;
    end
    @(posedge in_clk);
    #1;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge in_clk);
      #1;
      waited++;
      if (waited > DRAIN_LIMIT) report_failure("Timeout waiting for commits to drain");
    end
    idle(6);  // Catch stray commits
  endtask

  // Commit is stable mid-cycle
  always @(negedge in_clk) begin
    commit_t exp;
    if (in_rst_n && commit.valid) begin
      assert (exp_q.size() > 0)
        else report_failure("Commit seen with no accepted instruction outstanding");
      exp = exp_q.pop_front();
      assert (commit.tag == exp.tag)
        else report_failure($sformatf("Mismatch on commit.tag: got %h expected %h",
                                      commit.tag, exp.tag));
      assert (commit.dst == exp.dst)
        else report_failure($sformatf("Mismatch on commit.dst: got %h expected %h",
                                      commit.dst, exp.dst));
      assert (commit.value == exp.value)
        else report_failure($sformatf("Mismatch on commit.value: got %h expected %h",
                                      commit.value, exp.value));
      assert (commit.set_flags == exp.set_flags)
        else report_failure($sformatf("Mismatch on commit.set_flags: got %h expected %h",
                                      commit.set_flags, exp.set_flags));
      if (exp.set_flags) begin
        assert (commit.nzcv == exp.nzcv)
          else report_failure($sformatf("Mismatch on commit.nzcv: got %h expected %h",
                                        commit.nzcv, exp.nzcv));
      end
    end
  end

  initial begin
    insn_t       in;
    op_e         op;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] cnd;
    logic [31:0] imm;
    logic [31:0] sf;
    in_rst_n       = 1'b0;
    dispatch_valid = 1'b0;
    insn           = '0;
    lfsr           = 32'h372347cf;
    model_flags    = '0;
    next_tag       = '0;
    dropped        = 0;
    for (int i = 0; i < NUM_GPR; i++) begin
      model_gpr[i] = '0;
    end
    repeat (16) @(posedge in_clk);
    #1 in_rst_n = 1'b1;

    // Quiet period after reset and then independent ADDI
    for (int i = 0; i < 10; i++) begin
      assert (dispatch_ready) else report_failure("dispatch_ready low with no traffic");
      assert (!commit.valid) else report_failure("Commit valid with no traffic");
      idle(1);
    end
    for (int i = 0; i < 8; i++) begin
      send(make_insn(OP_ADDI, i, 0, 0, COND_EQ, 100 * i + 7, 1'b0));
    end
    drain();

    // Dependent chains back to back and spaced
    send(make_insn(OP_ADDI, 1, 0, 0, COND_EQ, 5, 1'b0));
    send(make_insn(OP_ADDI, 2, 0, 0, COND_EQ, 7, 1'b0));
    send(make_insn(OP_ADD, 3, 1, 2, COND_EQ, 0, 1'b0));
    send(make_insn(OP_SUB, 4, 3, 1, COND_EQ, 0, 1'b0));
    send(make_insn(OP_AND, 5, 4, 3, COND_EQ, 0, 1'b0));
    send(make_insn(OP_MUL, 6, 3, 4, COND_EQ, 0, 1'b0));
    send(make_insn(OP_ADD, 7, 6, 1, COND_EQ, 0, 1'b0));
    send(make_insn(OP_MUL, 8, 2, 2, COND_EQ, 0, 1'b0));
    send(make_insn(OP_ADDI, 9, 0, 0, COND_EQ, 33, 1'b0));  // Finishes before the MUL
    idle(6);
    send(make_insn(OP_SUB, 10, 8, 7, COND_EQ, 0, 1'b0));  // Sources already stored
    idle(2);
    send(make_insn(OP_MUL, 11, 10, 6, COND_EQ, 0, 1'b0));
    drain();

    // Flag setters followed by CSEL on each condition
    send(make_insn(OP_ADDI, 10, 0, 0, COND_EQ, 3, 1'b0));
    send(make_insn(OP_ADDI, 11, 0, 0, COND_EQ, 9, 1'b0));
    for (int s = 0; s < 4; s++) begin
      case (s)
        0: send(make_insn(OP_SUB, 12, 10, 10, COND_EQ, 0, 1'b1));
        1: send(make_insn(OP_SUB, 12, 10, 11, COND_EQ, 0, 1'b1));
        2: send(make_insn(OP_SUB, 12, 11, 10, COND_EQ, 0, 1'b1));
        default: send(make_insn(OP_AND, 12, 10, 11, COND_EQ, 0, 1'b1));
      endcase
      for (int c = 0; c < 4; c++) begin
        send(make_insn(OP_CSEL, 13, 10, 11, cond_e'(2'(c)), 0, 1'b0));
        idle(s);
      end
    end
    drain();

    // MUL burst until the buffer fills
    for (int i = 0; i < 24; i++) begin
      strobe_blind(make_insn(OP_MUL, 1 + (i % 3), 1 + ((i + 1) % 3), 2, COND_EQ, 0, 1'b0));
    end
    dispatch_valid = 1'b0;
    assert (dropped > 0) else report_failure("dispatch_ready never dropped during the burst");
    drain();

    // Random instructions with random gaps
    for (int k = 0; k < 400; k++) begin
      op  = op_e'(3'(take_bits(3) % 32'd6));
      rd  = take_bits(4);
      rs1 = take_bits(4);
      rs2 = take_bits(4);
      cnd = take_bits(2);
      imm = take_bits(12);
      sf  = take_bits(1);
      in  = make_insn(op, int'(rd), int'(rs1), int'(rs2), cond_e'(cnd[1:0]), int'(imm), sf[0]);
      send(in);
      idle(int'(take_bits(2)));
    end
    drain();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
